// File: rtl/fim_pkg.sv
`default_nettype none

package fim_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  localparam int DATA_W  = 32;
  localparam int ADDR_W  = 16;
  localparam int NUM_CSR = 4;   // Addr 0 is ID, 1..3 scratch

  // Value returned by the ID register
  localparam logic [DATA_W-1:0] FIM_ID = 32'h0F1A_5E11;

  // --------------------------------------------------
  // Command and response encodings
  // --------------------------------------------------
  typedef enum logic [2:0] {
    OP_CSR_RD = 3'd0,
    OP_CSR_WR = 3'd1,
    OP_MEM_RD = 3'd2,
    OP_MEM_WR = 3'd3   // 3'd4 to 3'd7 are illegal
  } cmd_op_e;

  typedef enum logic [1:0] {
    ST_OK       = 2'd0,
    ST_BAD_OP   = 2'd1,
    ST_BAD_ADDR = 2'd2
  } rsp_status_e;

  // Decoded destination of a command
  typedef enum logic {
    TGT_CSR = 1'b0,
    TGT_MEM = 1'b1
  } target_e;

endpackage

`default_nettype wire

// File: rtl/host_cmd_decode.sv
`timescale 1ns/10ps
`default_nettype none

module host_cmd_decode #(
  parameter int mem_aw = 8
) (
  input  wire                                sys_refclk,
  input  wire                                reset,
  // Host command port
  input  wire                                cmd_req,
  input  wire fim_pkg::cmd_op_e              cmd_op,
  input  wire [fim_pkg::ADDR_W-1:0]          cmd_addr,
  input  wire [fim_pkg::DATA_W-1:0]          cmd_wdata,
  output logic                               cmd_ack,
  // Decoded command towards execute
  output logic                               dec_valid,
  output fim_pkg::target_e                   dec_target,
  output logic                               dec_write,
  output logic [fim_pkg::ADDR_W-1:0]         dec_addr,
  output logic [fim_pkg::DATA_W-1:0]         dec_wdata,
  output fim_pkg::rsp_status_e               dec_status,
  input  wire                                dec_take
);

  import fim_pkg::*;

  target_e     op_target;
  logic        op_write;
  logic        op_legal;
  logic        addr_bad;
  rsp_status_e op_status;
  logic        capture;

  // --------------------------------------------------
  // Opcode and address classification
  // --------------------------------------------------
  always_comb begin
    op_target = TGT_CSR;
    op_write  = 1'b0;
    op_legal  = 1'b1;
    case (cmd_op)
      OP_CSR_RD: op_target = TGT_CSR;
      OP_CSR_WR: op_write  = 1'b1;
      OP_MEM_RD: op_target = TGT_MEM;
      OP_MEM_WR: begin
        op_target = TGT_MEM;
        op_write  = 1'b1;
      end
      default:   op_legal  = 1'b0;
    endcase
  end

  // Memory range is limited to the implemented address bits
  assign addr_bad = (op_target == TGT_CSR) ? (cmd_addr >= ADDR_W'(NUM_CSR))
                                           : ((cmd_addr >> mem_aw) != '0);

  always_comb begin
    if (!op_legal) begin
      op_status = ST_BAD_OP;
    end else if (addr_bad) begin
      op_status = ST_BAD_ADDR;
    end else begin
      op_status = ST_OK;
    end
  end

  // New command only when register empty and previous handshake closed
  assign capture = cmd_req && !cmd_ack && !dec_valid;

  // --------------------------------------------------
  // Handshake and command register
  // --------------------------------------------------
  always_ff @(posedge sys_refclk) begin
    if (reset) begin
      cmd_ack   <= 1'b0;
      dec_valid <= 1'b0;
    end else begin
      if (capture) begin
        cmd_ack   <= 1'b1;
        dec_valid <= 1'b1;
      end else begin
        if (cmd_ack && !cmd_req) cmd_ack <= 1'b0;  // Phase 4
        if (dec_take) dec_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge sys_refclk) begin
    if (capture) begin
      dec_target <= op_target;
      dec_write  <= op_write;
      dec_addr   <= cmd_addr;
      dec_wdata  <= cmd_wdata;
      dec_status <= op_status;
    end
  end

  // Host keeps req and fields steady until the ack comes back
  a_req_held : assert property (@(posedge sys_refclk) disable iff (reset)
    cmd_req && !cmd_ack |=> cmd_req && $stable(cmd_op) && $stable(cmd_addr)
                            && $stable(cmd_wdata));

endmodule

`default_nettype wire

// File: rtl/csr_mem_execute.sv
`timescale 1ns/10ps
`default_nettype none

module csr_mem_execute #(
  parameter int mem_aw = 8
) (
  input  wire                                sys_refclk,
  input  wire                                reset,
  // Decoded command
  input  wire                                dec_valid,
  input  wire fim_pkg::target_e              dec_target,
  input  wire                                dec_write,
  input  wire [fim_pkg::ADDR_W-1:0]          dec_addr,
  input  wire [fim_pkg::DATA_W-1:0]          dec_wdata,
  input  wire fim_pkg::rsp_status_e          dec_status,
  output logic                               dec_take,
  // Result towards the response stage
  output logic                               ex_valid,
  output logic [fim_pkg::DATA_W-1:0]         ex_rdata,
  output fim_pkg::rsp_status_e               ex_status,
  input  wire                                res_full,
  // Memory port
  output logic                               mem_req,
  output logic                               mem_we,
  output logic [mem_aw-1:0]                  mem_addr,
  output logic [fim_pkg::DATA_W-1:0]         mem_wdata,
  input  wire                                mem_ack,
  input  wire [fim_pkg::DATA_W-1:0]          mem_rdata
);

  import fim_pkg::*;

  localparam int CSR_AW = $clog2(NUM_CSR);

  typedef enum logic [1:0] {
    EX_IDLE,
    EX_MEM_REQ,    // req high, waiting for ack
    EX_MEM_ACK,    // req low, waiting for ack to drop
    EX_RESULT
  } ex_state_e;

  ex_state_e         state;
  logic [DATA_W-1:0] scratch [1:NUM_CSR-1];
  logic [CSR_AW-1:0] csr_idx;
  logic [DATA_W-1:0] csr_rdata;
  logic              cmd_ok;
  logic              mem_start;
  logic              csr_wr_en;
  logic              csr_rd;

  assign dec_take  = (state == EX_IDLE) && dec_valid;
  assign cmd_ok    = (dec_status == ST_OK);
  assign mem_start = dec_take && cmd_ok && (dec_target == TGT_MEM);
  assign csr_idx   = dec_addr[CSR_AW-1:0];
  assign csr_wr_en = dec_take && cmd_ok && (dec_target == TGT_CSR) && dec_write;
  assign csr_rd    = cmd_ok && (dec_target == TGT_CSR) && !dec_write;

  assign ex_valid  = (state == EX_RESULT) && !res_full;

  // --------------------------------------------------
  // Register read mux
  // --------------------------------------------------
  always_comb begin
    csr_rdata = FIM_ID;
    for (int i = 1; i < NUM_CSR; i++) begin
      if (csr_idx == CSR_AW'(i)) csr_rdata = scratch[i];
    end
  end

  // --------------------------------------------------
  // Sequencer and scratch registers
  // --------------------------------------------------
  always_ff @(posedge sys_refclk) begin
    if (reset) begin
      state   <= EX_IDLE;
      mem_req <= 1'b0;
      for (int i = 1; i < NUM_CSR; i++) begin
        scratch[i] <= '0;
      end
    end else begin
      // Write to the ID address falls through untouched
      for (int i = 1; i < NUM_CSR; i++) begin
        if (csr_wr_en && csr_idx == CSR_AW'(i)) scratch[i] <= dec_wdata;
      end
      case (state)
        EX_IDLE: begin
          if (mem_start) begin
            mem_req <= 1'b1;
            state   <= EX_MEM_REQ;
          end else if (dec_take) begin
            state   <= EX_RESULT;   // CSR or error, one cycle
          end
        end
        EX_MEM_REQ: begin
          if (mem_ack) begin
            mem_req <= 1'b0;
            state   <= EX_MEM_ACK;
          end
        end
        EX_MEM_ACK: if (!mem_ack) state <= EX_RESULT;
        EX_RESULT:  if (!res_full) state <= EX_IDLE;
        default:    state <= EX_IDLE;
      endcase
    end
  end

  // Payload of the command in progress
  always_ff @(posedge sys_refclk) begin
    if (mem_start) begin
      mem_we    <= dec_write;
      mem_addr  <= dec_addr[mem_aw-1:0];
      mem_wdata <= dec_wdata;
    end
    if (dec_take) begin
      ex_status <= dec_status;
      ex_rdata  <= csr_rd ? csr_rdata : '0;   // Writes and errors return zero
    end else if (state == EX_MEM_REQ && mem_ack && !mem_we) begin
      ex_rdata  <= mem_rdata;
    end
  end

  a_mem_stable : assert property (@(posedge sys_refclk) disable iff (reset)
    mem_req && $past(mem_req) |-> $stable(mem_addr) && $stable(mem_we));

endmodule

`default_nettype wire

// File: rtl/host_rsp_result.sv
`timescale 1ns/10ps
`default_nettype none

module host_rsp_result (
  input  wire                                sys_refclk,
  input  wire                                reset,
  // Result from execute
  input  wire                                ex_valid,
  input  wire [fim_pkg::DATA_W-1:0]          ex_rdata,
  input  wire fim_pkg::rsp_status_e          ex_status,
  output logic                               res_full,
  // Host response port
  output logic                               rsp_req,
  output logic [fim_pkg::DATA_W-1:0]         rsp_rdata,
  output fim_pkg::rsp_status_e               rsp_status,
  input  wire                                rsp_ack
);

  import fim_pkg::*;

  typedef enum logic [1:0] {
    RS_EMPTY,
    RS_LOADED,
    RS_REQ,
    RS_DROP     // Waiting for ack to return low
  } rs_state_e;

  rs_state_e state;

  assign res_full = (state != RS_EMPTY);

  // --------------------------------------------------
  // Response handshake
  // --------------------------------------------------
  always_ff @(posedge sys_refclk) begin
    if (reset) begin
      state   <= RS_EMPTY;
      rsp_req <= 1'b0;
    end else begin
      case (state)
        RS_EMPTY:  if (ex_valid) state <= RS_LOADED;
        RS_LOADED: begin
          rsp_req <= 1'b1;
          state   <= RS_REQ;
        end
        RS_REQ: begin
          if (rsp_ack) begin
            rsp_req <= 1'b0;
            state   <= RS_DROP;
          end
        end
        RS_DROP:   if (!rsp_ack) state <= RS_EMPTY;
        default:   state <= RS_EMPTY;
      endcase
    end
  end

  always_ff @(posedge sys_refclk) begin
    if (state == RS_EMPTY && ex_valid) begin
      rsp_rdata  <= ex_rdata;
      rsp_status <= ex_status;
    end
  end

  a_rsp_stable : assert property (@(posedge sys_refclk) disable iff (reset)
    rsp_req && $past(rsp_req) |-> $stable(rsp_rdata) && $stable(rsp_status));

endmodule

`default_nettype wire

// File: rtl/fim_top.sv
`timescale 1ns/10ps
`default_nettype none

module fim_top #(
  parameter int mem_aw = 8
) (
  input  wire                                sys_refclk,
  input  wire                                reset,
  // Host command port
  input  wire                                cmd_req,
  input  wire fim_pkg::cmd_op_e              cmd_op,
  input  wire [fim_pkg::ADDR_W-1:0]          cmd_addr,
  input  wire [fim_pkg::DATA_W-1:0]          cmd_wdata,
  output logic                               cmd_ack,
  // Host response port
  output logic                               rsp_req,
  output logic [fim_pkg::DATA_W-1:0]         rsp_rdata,
  output fim_pkg::rsp_status_e               rsp_status,
  input  wire                                rsp_ack,
  // Memory port
  output logic                               mem_req,
  output logic                               mem_we,
  output logic [mem_aw-1:0]                  mem_addr,
  output logic [fim_pkg::DATA_W-1:0]         mem_wdata,
  input  wire                                mem_ack,
  input  wire [fim_pkg::DATA_W-1:0]          mem_rdata
);

  import fim_pkg::*;

  // --------------------------------------------------
  // Stage to stage signals
  // --------------------------------------------------
  logic              dec_valid;
  target_e           dec_target;
  logic              dec_write;
  logic [ADDR_W-1:0] dec_addr;
  logic [DATA_W-1:0] dec_wdata;
  rsp_status_e       dec_status;
  logic              dec_take;

  logic              ex_valid;
  logic [DATA_W-1:0] ex_rdata;
  rsp_status_e       ex_status;
  logic              res_full;

  host_cmd_decode #(.mem_aw(mem_aw)) u_decode (
    .sys_refclk, .reset,
    .cmd_req, .cmd_op, .cmd_addr, .cmd_wdata, .cmd_ack,
    .dec_valid, .dec_target, .dec_write, .dec_addr, .dec_wdata, .dec_status,
    .dec_take
  );

  csr_mem_execute #(.mem_aw(mem_aw)) u_execute (
    .sys_refclk, .reset,
    .dec_valid, .dec_target, .dec_write, .dec_addr, .dec_wdata, .dec_status,
    .dec_take,
    .ex_valid, .ex_rdata, .ex_status, .res_full,
    .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata
  );

  host_rsp_result u_result (
    .sys_refclk, .reset,
    .ex_valid, .ex_rdata, .ex_status, .res_full,
    .rsp_req, .rsp_rdata, .rsp_status, .rsp_ack
  );

endmodule

`default_nettype wire

// File: tb/sim_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module sim_mem_model #(
  parameter int aw = 8
) (
  input  wire                        sys_refclk,
  input  wire                        reset,
  input  wire                        mem_req,
  input  wire                        mem_we,
  input  wire [aw-1:0]               mem_addr,
  input  wire [fim_pkg::DATA_W-1:0]  mem_wdata,
  output logic                       mem_ack,
  output logic [fim_pkg::DATA_W-1:0] mem_rdata
);

  import fim_pkg::*;

  localparam int DEPTH    = 1 << aw;
  localparam int DROP_MAX = 64;   // Bound on waiting for req to fall

  logic [DATA_W-1:0] mem [DEPTH];
  integer            seed;
  int                n;

  // Random stall of 0 to 5 cycles
  task automatic random_wait();
    int delay;
    delay = int'($unsigned($random(seed)) % 6);
    repeat (delay) @(posedge sys_refclk);
  endtask

  initial begin
    seed      = 32'h9940;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = 32'h5A00_0000 ^ (32'(i) * 32'h0001_0101);
    end
    forever begin
      @(posedge sys_refclk);
      if (!reset && mem_req) begin
        random_wait();
        if (mem_we) begin
          mem[mem_addr] <= mem_wdata;
        end else begin
          mem_rdata <= mem[mem_addr];   // Held until the next read
        end
        mem_ack <= 1'b1;
        n = 0;
        do begin
          @(posedge sys_refclk);
          n++;
        end while (mem_req && n < DROP_MAX);
        random_wait();
        mem_ack <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: tb/top_tb.sv
`timescale 1ns/10ps
`default_nettype none

module top_tb;

  import fim_pkg::*;

  localparam int MEM_AW    = 8;
  localparam int MAX_ROWS  = 48;
  localparam int WAIT_MAX  = 200;   // Cycles per handshake step
  localparam int STALL_LEN = 40;

  logic              sys_refclk = 1'b0;
  logic              reset;
  logic              cmd_req, cmd_ack, rsp_req, rsp_ack;
  logic              mem_req, mem_we, mem_ack;
  cmd_op_e           cmd_op;
  logic [ADDR_W-1:0] cmd_addr;
  logic [DATA_W-1:0] cmd_wdata, rsp_rdata, mem_wdata, mem_rdata;
  rsp_status_e       rsp_status;
  logic [MEM_AW-1:0] mem_addr;

  // Stimulus table, one command per row
  logic [2:0]        tab_op     [MAX_ROWS];
  logic [ADDR_W-1:0] tab_addr   [MAX_ROWS];
  logic [DATA_W-1:0] tab_wdata  [MAX_ROWS];
  logic [DATA_W-1:0] tab_rdata  [MAX_ROWS];
  logic [1:0]        tab_status [MAX_ROWS];
  int                n_rows;
  int                stall_row;   // First of the four back-pressure rows
  logic [DATA_W-1:0] shadow [1 << MEM_AW];
  integer            seed;
  int                mem_rises;
  int                exp_rises;
  logic              mem_req_q;

  always #50 sys_refclk = ~sys_refclk;

  fim_top #(.mem_aw(MEM_AW)) u_dut (.*);

  sim_mem_model #(.aw(MEM_AW)) u_mem (.*);

  // Rising edges of mem_req
  always @(posedge sys_refclk) begin
    if (reset) begin
      mem_rises <= 0;
      mem_req_q <= 1'b0;
    end else begin
      if (mem_req && !mem_req_q) mem_rises <= mem_rises + 1;
      mem_req_q <= mem_req;
    end
  end

  // --------------------------------------------------
  // Checking and handshake helpers
  // --------------------------------------------------
  task automatic stop_on_error();
    $display("Test failed");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
      stop_on_error();
    end
  endtask

  task automatic wait_line(input bit use_rsp, input logic level, input string what);
    int n;
    n = 0;
    do begin
      @(posedge sys_refclk);
      n++;
    end while (((use_rsp ? rsp_req : cmd_ack) !== level) && n < WAIT_MAX);
    if ((use_rsp ? rsp_req : cmd_ack) !== level) begin
      $display("Timeout at %0t while waiting for %s", $time, what);
      stop_on_error();
    end
  endtask

  task automatic raise_command(input int i);
    @(posedge sys_refclk);
    cmd_req   <= 1'b1;
    cmd_op    <= cmd_op_e'(tab_op[i]);
    cmd_addr  <= tab_addr[i];
    cmd_wdata <= tab_wdata[i];
  endtask

  task automatic finish_command();
    wait_line(1'b0, 1'b1, "cmd_ack to rise");
    cmd_req <= 1'b0;
    wait_line(1'b0, 1'b0, "cmd_ack to fall");
  endtask

  task automatic take_response(input int i);
    wait_line(1'b1, 1'b1, "rsp_req to rise");
    check_value("rsp_rdata", rsp_rdata, tab_rdata[i]);
    check_value("rsp_status", 32'(rsp_status), 32'(tab_status[i]));
    rsp_ack <= 1'b1;
    wait_line(1'b1, 1'b0, "rsp_req to fall");
    rsp_ack <= 1'b0;
  endtask

  // Only accepted memory commands reach the memory port
  function automatic bit mem_used(input int i);
    return (tab_op[i] == OP_MEM_RD || tab_op[i] == OP_MEM_WR) && tab_status[i] == ST_OK;
  endfunction

  // --------------------------------------------------
  // Table construction
  // --------------------------------------------------
  task automatic add_row(input logic [2:0] op, input logic [ADDR_W-1:0] addr,
                         input logic [DATA_W-1:0] wdata, input logic [DATA_W-1:0] rdata,
                         input logic [1:0] status);
    tab_op[n_rows]     = op;
    tab_addr[n_rows]   = addr;
    tab_wdata[n_rows]  = wdata;
    tab_rdata[n_rows]  = rdata;
    tab_status[n_rows] = status;
    n_rows++;
  endtask

  task automatic add_mem_write(input logic [MEM_AW-1:0] addr);
    logic [DATA_W-1:0] data;
    data = $random(seed);
    shadow[addr] = data;
    add_row(OP_MEM_WR, ADDR_W'(addr), data, '0, ST_OK);
  endtask

  task automatic add_mem_read(input logic [MEM_AW-1:0] addr);
    add_row(OP_MEM_RD, ADDR_W'(addr), '0, shadow[addr], ST_OK);
  endtask

  task automatic build_table();
    logic [MEM_AW-1:0] picks [6];
    picks = '{8'h00, 8'h01, 8'h5A, 8'hA5, 8'hFE, 8'hFF};
    n_rows = 0;
    add_row(OP_CSR_RD, 16'h0000, '0, FIM_ID, ST_OK);
    add_row(OP_CSR_WR, 16'h0001, 32'h1111_0001, '0, ST_OK);
    add_row(OP_CSR_WR, 16'h0002, 32'h2222_0002, '0, ST_OK);
    add_row(OP_CSR_WR, 16'h0003, 32'h3333_0003, '0, ST_OK);
    add_row(OP_CSR_WR, 16'h0000, 32'hDEAD_BEEF, '0, ST_OK);   // ID stays put
    add_row(OP_CSR_RD, 16'h0001, '0, 32'h1111_0001, ST_OK);
    add_row(OP_CSR_RD, 16'h0002, '0, 32'h2222_0002, ST_OK);
    add_row(OP_CSR_RD, 16'h0003, '0, 32'h3333_0003, ST_OK);
    add_row(OP_CSR_RD, 16'h0000, '0, FIM_ID, ST_OK);
    foreach (picks[k]) add_mem_write(picks[k]);
    foreach (picks[k]) add_mem_read(picks[k]);
    add_mem_write(8'h5A);
    add_mem_read(8'h5A);
    // Rejected commands, data always zero
    add_row(3'd4, 16'h0000, '0, '0, ST_BAD_OP);
    add_row(3'd7, 16'h0001, 32'h1234_5678, '0, ST_BAD_OP);
    add_row(OP_CSR_RD, 16'h0004, '0, '0, ST_BAD_ADDR);
    add_row(OP_CSR_WR, 16'h8001, 32'hFFFF_FFFF, '0, ST_BAD_ADDR);
    add_row(OP_MEM_RD, 16'h0100, '0, '0, ST_BAD_ADDR);
    add_row(OP_MEM_WR, 16'h0100, 32'hBAD0_BAD0, '0, ST_BAD_ADDR);  // Aliases addr 0
    add_mem_read(8'h00);
    add_row(OP_CSR_RD, 16'h0001, '0, 32'h1111_0001, ST_OK);
    stall_row = n_rows;
    add_row(OP_CSR_RD, 16'h0000, '0, FIM_ID, ST_OK);
    add_mem_write(8'h33);
    add_mem_read(8'h33);
    add_row(OP_CSR_RD, 16'h0003, '0, 32'h3333_0003, ST_OK);
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    int n;
    seed      = 32'h9940;
    reset     = 1'b1;
    cmd_req   = 1'b0;
    cmd_op    = OP_CSR_RD;
    cmd_addr  = '0;
    cmd_wdata = '0;
    rsp_ack   = 1'b0;
    exp_rises = 0;
    build_table();
    repeat (16) @(posedge sys_refclk);
    reset <= 1'b0;

    for (int i = 0; i < stall_row; i++) begin
      raise_command(i);
      finish_command();
      take_response(i);
      if (mem_used(i)) exp_rises++;
      check_value("mem_req rises", mem_rises, exp_rises);
    end

    // Fill decode, execute and result with rsp_ack held low
    for (int i = stall_row; i < stall_row + 3; i++) begin
      raise_command(i);
      finish_command();
    end
    raise_command(stall_row + 3);
    n = 0;
    while (!cmd_ack && n < STALL_LEN) begin
      @(posedge sys_refclk);
      n++;
    end
    if (cmd_ack) begin
      $display("cmd_ack rose at %0t although every stage was full", $time);
      stop_on_error();
    end
    for (int i = stall_row; i < stall_row + 3; i++) take_response(i);
    finish_command();
    take_response(stall_row + 3);
    for (int i = stall_row; i < n_rows; i++) begin
      if (mem_used(i)) exp_rises++;
    end
    check_value("mem_req rises", mem_rises, exp_rises);

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
rtl/fim_pkg.sv
rtl/host_cmd_decode.sv
rtl/csr_mem_execute.sv
rtl/host_rsp_result.sv
rtl/fim_top.sv
tb/sim_mem_model.sv
tb/top_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = top_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
